// ==== cpu_core.f ====
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/control_logic.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_unit.sv
hdl/cpu_core.sv
tb/cpu_core_properties.sv
tb/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cpu_core.f --top-module tb_cpu_core -o sim_tb_cpu_core

output=$(./obj_dir/sim_tb_cpu_core)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// ==== tb/tb_cpu_core.sv ====
// Directed testbench; memories are 4K-word arrays, dmem indexed by the low 12 address bits
`timescale 1ns/10ps

module tb_cpu_core import cpu_isa_pkg::*; ();

	localparam int prog_instr = 150; // Rough sum of instructions over all programs
	localparam int run_cycles = prog_instr + 6 * 4 + 40; // Plus resets and post-halt waits
	localparam int watchdog_ns = run_cycles * 8 * 2 + 1000;
	localparam int halt_limit = 400; // Cycles allowed per program

	logic clk;
	logic arst_n;
	logic [pc_width-1:0] imem_addr;
	logic [data_width-1:0] imem_data, dmem_addr, dmem_wdata, dmem_rdata;
	logic dmem_we, dmem_re, halted;
	logic [data_width-1:0] imem [4096];
	logic [data_width-1:0] dmem [4096];
	logic [data_width-1:0] st_addr[$], st_data[$], exp_addr[$], exp_data[$];
	logic [data_width-1:0] ld_addr[$], exp_ld[$]; // Read strobes seen and expected
	int ptr; // Next instruction slot
	int errors = 0;
	int checks = 0;

	cpu_core UUT (.*);

	bind cpu_core cpu_core_properties u_props (.clk(clk), .arst_n(arst_n), .dmem_we(dmem_we),
		.dmem_re(dmem_re), .halted(halted), .imem_addr(imem_addr));

	assign imem_data = imem[imem_addr];
	assign dmem_rdata = dmem[dmem_addr[11:0]]; // Combinational read

	always #4 clk = ~clk;

	// Write port, store log and load log
	always @(posedge clk) begin
		if (arst_n && dmem_we) begin
			dmem[dmem_addr[11:0]] <= dmem_wdata;
			st_addr.push_back(dmem_addr);
			st_data.push_back(dmem_wdata);
		end
		if (arst_n && dmem_re) begin
			ld_addr.push_back(dmem_addr);
		end
	end

	function automatic logic [15:0] rtype(opcode_t op, logic [3:0] rd, logic [3:0] r1,
		logic [3:0] r2);
		return {op, rd, r1, r2};
	endfunction

	function automatic logic [15:0] itype(opcode_t op, logic [3:0] rd, logic [7:0] imm);
		return {op, rd, imm};
	endfunction

	function automatic logic [15:0] bword(cond_t c, logic [8:0] off);
		return {B, c, off};
	endfunction

	// ISA rules for the register-form ops
	function automatic logic [15:0] alu_model(opcode_t op, logic [15:0] a, logic [15:0] b);
		case (op)
			ADD: return a + b;
			SUB: return a - b;
			NAND: return ~(a & b);
			XOR: return a ^ b;
			SRA: return $signed(a) >>> b[3:0];
			SRL: return a >> b[3:0];
			default: return a << b[3:0]; // SLL
		endcase
	endfunction

	function automatic bit cond_holds(int c, bit z, bit n, bit v);
		case (c)
			0: return z;
			1: return n && !z;
			2: return !n && !z;
			3: return v;
			4: return !z;
			5: return !n;
			6: return n || z;
			default: return 1'b1;
		endcase
	endfunction

	task automatic emit(logic [15:0] word);
		imem[ptr] = word;
		ptr++;
	endtask

	task automatic expect_store(logic [15:0] a, logic [15:0] d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic expect_load(logic [15:0] a);
		exp_ld.push_back(a);
	endtask

	// Hold reset and refill both memories
	task automatic start_program();
		arst_n = 1'b0;
		for (int i = 0; i < 4096; i++) begin
			imem[i] = {ERR, 12'(i)}; // Stray fetch halts
			dmem[i] = 16'(i) ^ 16'ha5a5;
		end
		st_addr.delete();
		st_data.delete();
		exp_addr.delete();
		exp_data.delete();
		ld_addr.delete();
		exp_ld.delete();
		ptr = 0;
	endtask

	task automatic run_program(input string name, input int halt_pc, input int extra);
		int cycles;
		cycles = 0;
		repeat (3) @(posedge clk);
		#1 arst_n = 1'b1;
		while (!halted && cycles < halt_limit) begin
			@(posedge clk);
			#1 cycles++;
		end
		assert (halted) else begin
			errors++;
			$display("%s: core did not halt within %0d cycles", name, halt_limit);
		end
		repeat (extra) @(posedge clk);
		#1 checks++;
		assert (st_addr.size() == exp_addr.size()) else begin
			errors++;
			$display("%s: logged %0d stores but expected %0d", name, st_addr.size(),
				exp_addr.size());
		end
		for (int i = 0; i < exp_addr.size() && i < st_addr.size(); i++) begin
			checks += 2;
			assert (st_addr[i] == exp_addr[i]) else begin
				errors++;
				$display("error %s dmem_addr store %0d exp %h got %h", name, i, exp_addr[i],
					st_addr[i]);
			end
			assert (st_data[i] == exp_data[i]) else begin
				errors++;
				$display("error %s dmem_wdata store %0d exp %h got %h", name, i, exp_data[i],
					st_data[i]);
			end
		end
		checks++;
		assert (ld_addr.size() == exp_ld.size()) else begin
			errors++;
			$display("%s: logged %0d loads but expected %0d", name, ld_addr.size(),
				exp_ld.size());
		end
		for (int i = 0; i < exp_ld.size() && i < ld_addr.size(); i++) begin
			checks++;
			assert (ld_addr[i] == exp_ld[i]) else begin
				errors++;
				$display("error %s dmem_addr load %0d exp %h got %h", name, i, exp_ld[i],
					ld_addr[i]);
			end
		end
		checks++;
		assert (imem_addr == 12'(halt_pc)) else begin
			errors++;
			$display("error %s imem_addr exp %h got %h", name, 12'(halt_pc), imem_addr);
		end
	endtask

	task automatic test_alu_ops();
		opcode_t ops[7] = '{ADD, SUB, NAND, XOR, SRA, SRL, SLL};
		logic [15:0] a, b;
		a = 16'($urandom);
		b = 16'($urandom);
		start_program();
		emit(itype(LLB, reg_ds, 8'h20));
		emit(itype(LLB, 1, a[7:0]));
		emit(itype(LHB, 1, a[15:8])); // Build full word
		emit(itype(LLB, 2, b[7:0]));
		emit(itype(LHB, 2, b[15:8]));
		for (int k = 0; k < 7; k++) begin
			emit(rtype(ops[k], 3, 1, 2));
			emit(itype(SW, 3, 8'(k)));
			expect_store(16'(16'h20 + k), alu_model(ops[k], a, b));
		end
		emit({ERR, 12'h0});
		run_program("alu_ops", ptr - 1, 4);
	endtask

	task automatic test_imm_loads();
		start_program();
		emit(itype(LLB, reg_ds, 8'h20));
		emit(itype(LLB, 1, 8'h85)); // Negative byte
		emit(itype(SW, 1, 8'd0));
		emit(itype(LHB, 1, 8'h12));
		emit(itype(SW, 1, 8'd1));
		emit(rtype(INC, 2, 1, 4'hd)); // Minus three
		emit(itype(SW, 2, 8'd2));
		emit(rtype(INC, 3, 1, 4'h7));
		emit(itype(SW, 3, 8'd3));
		emit({ERR, 12'h0});
		expect_store(16'h20, 16'hff85);
		expect_store(16'h21, 16'h1285);
		expect_store(16'h22, 16'h1282);
		expect_store(16'h23, 16'h128c);
		run_program("imm_loads", ptr - 1, 4);
	endtask

	task automatic test_load_store();
		logic [15:0] v;
		v = 16'($urandom);
		start_program();
		emit(itype(LLB, reg_ds, 8'h30));
		emit(itype(LHB, reg_ds, 8'h01)); // Segment 0x0130
		emit(itype(LLB, 1, v[7:0]));
		emit(itype(LHB, 1, v[15:8]));
		emit(itype(SW, 1, 8'h25));
		emit(itype(LW, 5, 8'h25));
		emit(itype(SW, 5, 8'h26)); // Echo the loaded word
		emit({ERR, 12'h0});
		expect_store(16'h0155, v);
		expect_store(16'h0156, v);
		expect_load(16'h0155);
		run_program("load_store", ptr - 1, 4);
	endtask

	task automatic test_branches();
		logic [15:0] a, b, r;
		int sa, sb, sr;
		bit v;
		start_program();
		emit(itype(LLB, reg_ds, 8'h40));
		emit(itype(LLB, 7, 8'h5a)); // Marker
		for (int s = 0; s < 4; s++) begin
			case (s)
				0: begin // Zero
					a = 16'd5;
					b = 16'd5;
				end
				1: begin // Negative
					a = 16'd1;
					b = 16'd2;
				end
				2: begin // Overflow
					a = 16'h7fff;
					b = 16'd1;
				end
				default: begin // Positive
					a = 16'd1;
					b = 16'd2;
				end
			endcase
			emit(itype(LLB, 1, a[7:0]));
			emit(itype(LHB, 1, a[15:8]));
			emit(itype(LLB, 2, b[7:0]));
			emit(itype(LHB, 2, b[15:8]));
			sa = int'($signed(a));
			sb = int'($signed(b));
			if (s < 2) begin
				emit(rtype(SUB, 3, 1, 2));
				sr = sa - sb;
			end else begin
				emit(rtype(ADD, 3, 1, 2));
				sr = sa + sb;
			end
			r = 16'(sr);
			v = (sr > 32767) || (sr < -32768); // Exact sum outside signed 16-bit range
			for (int c = 0; c < 8; c++) begin
				emit(bword(cond_t'(c), 9'd1)); // Skip marker store when taken
				emit(itype(SW, 7, 8'(s * 8 + c)));
				if (!cond_holds(c, r == 0, r[15], v))
					expect_store(16'(16'h40 + s * 8 + c), 16'h005a);
			end
		end
		emit({ERR, 12'h0});
		run_program("branches", ptr - 1, 4);
	endtask

	task automatic test_call_ret();
		start_program();
		emit(itype(LLB, reg_ds, 8'h20));
		emit(itype(LLB, reg_sp, 8'h70));
		emit(itype(LLB, 7, 8'h11));
		emit({CALL, 12'd10});
		emit(itype(SW, 7, 8'd0)); // Back from outer call
		emit({ERR, 12'h0});
		ptr = 10;
		emit(itype(SW, 7, 8'd1));
		emit({CALL, 12'd20}); // Nested
		emit(itype(SW, 7, 8'd2));
		emit({RET, 12'h0});
		ptr = 20;
		emit(itype(SW, 7, 8'd3));
		emit({RET, 12'h0});
		expect_store(16'h006f, 16'd4); // Return address below sp
		expect_store(16'h0021, 16'h0011);
		expect_store(16'h006e, 16'd12);
		expect_store(16'h0023, 16'h0011);
		expect_store(16'h0022, 16'h0011);
		expect_store(16'h0020, 16'h0011);
		expect_load(16'h006e); // Inner RET pops first
		expect_load(16'h006f);
		run_program("call_ret", 5, 4);
	endtask

	task automatic test_halt();
		start_program();
		emit(itype(LLB, reg_ds, 8'h20));
		emit(itype(LLB, 1, 8'h05));
		emit(itype(SW, 1, 8'd0));
		emit({ERR, 12'h0});
		emit(itype(SW, 1, 8'd1)); // Never reached
		emit(itype(SW, 1, 8'd2));
		expect_store(16'h20, 16'h0005);
		run_program("halt", 3, 20);
	endtask

	initial begin
		#(watchdog_ns);
		$display("watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		void'($urandom(38));
		test_alu_ops();
		test_imm_loads();
		test_load_store();
		test_branches();
		test_call_ret();
		test_halt();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== tb/cpu_core_properties.sv ====
// Bound into cpu_core; all properties are disabled while arst_n is low
`timescale 1ns/10ps

module cpu_core_properties import cpu_isa_pkg::*; (
	input logic                clk,
	input logic                arst_n,
	input logic                dmem_we,
	input logic                dmem_re,
	input logic                halted,
	input logic [pc_width-1:0] imem_addr
);

	// Load and store never share a cycle
	strobe_excl: assert property (@(posedge clk) disable iff (!arst_n)
		!(dmem_we && dmem_re))
		else $error("dmem_we and dmem_re high together");

	// Frozen fetch and no stores once halted
	halt_frozen: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> ($stable(imem_addr) && !dmem_we))
		else $error("core moved or stored after halt");

	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted)
		else $error("halted fell without reset");

endmodule

// ==== hdl/cpu_core.sv ====
// Single-cycle core; both memories are read combinationally, halted clears only on arst_n
`timescale 1ns/10ps

module cpu_core import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic                  clk,
	input  logic                  arst_n,
	output logic [pc_width-1:0]   imem_addr,
	input  logic [data_width-1:0] imem_data,
	output logic [data_width-1:0] dmem_addr,
	output logic [data_width-1:0] dmem_wdata,
	output logic                  dmem_we,
	output logic                  dmem_re,
	input  logic [data_width-1:0] dmem_rdata,
	output logic                  halted
);

	logic [pc_width-1:0] pc;
	logic [pc_width-1:0] pc_inc; // Return address for CALL
	logic [pc_width-1:0] next_pc;
	ctrl_t ctrl_dec; // Straight from the decoder
	ctrl_t ctrl; // Same, with writes masked once halted
	logic [data_width-1:0] rd_data_1;
	logic [data_width-1:0] rd_data_2;
	logic [data_width-1:0] rd_data_d;
	logic [data_width-1:0] wr_data;
	logic [data_width-1:0] alu_result;
	flags_t alu_flags;

	control_logic u_control_logic (
		.opcode (opcode_t'(imem_data[opc_hi:opc_lo])),
		.cond   (cond_t'(imem_data[cond_hi:cond_lo])),
		.ctrl   (ctrl_dec)
	);

	// No state changes after halt
	always_comb begin
		ctrl = ctrl_dec;
		if (halted) begin
			ctrl.reg_write = 1'b0;
			ctrl.flag_write = 1'b0;
			ctrl.call = 1'b0;
			ctrl.rtrn = 1'b0;
			ctrl.reg_to_mem = 1'b0;
			ctrl.mem_to_reg = 1'b0;
		end
	end

	// Stack pointer port left open, the ALU sees sp on read port one
	reg_file u_reg_file (
		.clk       (clk),
		.arst_n    (arst_n),
		.ctrl      (ctrl),
		.rs1       (imem_data[rs1_hi:rs1_lo]),
		.rs2       (imem_data[rs2_hi:rs2_lo]),
		.rd        (imem_data[rd_hi:rd_lo]),
		.wr_data   (wr_data),
		.rd_data_1 (rd_data_1),
		.rd_data_2 (rd_data_2),
		.rd_data_d (rd_data_d),
		.sp        ()
	);

	alu u_alu (
		.ctrl      (ctrl),
		.a         (rd_data_1),
		.b         (rd_data_2),
		.instr_imm (imem_data[imm8_hi:imm8_lo]),
		.rd_old    (rd_data_d),
		.result    (alu_result),
		.flags     (alu_flags)
	);

	branch_unit u_branch_unit (
		.clk       (clk),
		.arst_n    (arst_n),
		.ctrl      (ctrl),
		.alu_flags (alu_flags),
		.pc        (pc),
		.offset    (imem_data[off_hi:off_lo]),
		.target    (imem_data[tgt_hi:tgt_lo]),
		.ret_addr  (dmem_rdata), // Word popped by RET
		.next_pc   (next_pc)
	);

	assign pc_inc = pc + 1'b1;
	assign wr_data = ctrl.mem_to_reg ? dmem_rdata : alu_result; // Writeback mux

	// Data memory port
	assign dmem_addr = alu_result;
	assign dmem_wdata = ctrl.call ? {{(data_width-pc_width){1'b0}}, pc_inc} : rd_data_d;
	assign dmem_we = (ctrl.reg_to_mem || ctrl.call) && !halted;
	assign dmem_re = (ctrl.mem_to_reg || ctrl.rtrn) && !halted;

	assign imem_addr = pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc <= '0;
			halted <= 1'b0;
		end else begin
			if (!halted) begin
				pc <= next_pc; // Holds on ERR via branch_unit
			end
			if (ctrl_dec.halt) begin
				halted <= 1'b1; // Sticky until reset
			end
		end
	end

endmodule

// ==== hdl/branch_unit.sv ====
// Flags survive until the next flag-setting op; branch offsets are relative to pc plus one
`timescale 1ns/10ps

module branch_unit import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic                 clk,
	input  logic                 arst_n,
	input  ctrl_t                ctrl,
	input  flags_t               alu_flags,
	input  logic [pc_width-1:0]  pc,
	input  logic [off_width-1:0] offset,
	input  logic [pc_width-1:0]  target,
	input  logic [data_width-1:0] ret_addr,
	output logic [pc_width-1:0]  next_pc
);

	flags_t flags_q;
	logic taken;
	logic [pc_width-1:0] seq_pc;
	logic [pc_width-1:0] br_pc;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			flags_q <= '0;
		end else if (ctrl.flag_write) begin
			flags_q <= alu_flags;
		end
	end

	// Condition on stored flags
	always_comb begin
		case (ctrl.cond)
			EQ: taken = flags_q.z;
			LT: taken = flags_q.n && !flags_q.z;
			GT: taken = !flags_q.n && !flags_q.z;
			OV: taken = flags_q.v;
			NE: taken = !flags_q.z;
			GE: taken = !flags_q.n;
			LE: taken = flags_q.n || flags_q.z;
			default: taken = 1'b1; // TR
		endcase
	end

	assign seq_pc = pc + 1'b1;
	assign br_pc = seq_pc + {{(pc_width-off_width){offset[off_width-1]}}, offset};

	always_comb begin
		if (ctrl.halt) begin
			next_pc = pc; // Park on ERR
		end else if (ctrl.call) begin
			next_pc = target;
		end else if (ctrl.rtrn) begin
			next_pc = ret_addr[pc_width-1:0]; // Popped word, low bits only
		end else if (ctrl.branch && taken) begin
			next_pc = br_pc;
		end else begin
			next_pc = seq_pc;
		end
	end

endmodule

// ==== hdl/alu.sv ====
// Combinational ALU; shifts use only the low four bits of operand two, v is set by add and sub
`timescale 1ns/10ps

module alu import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  ctrl_t                 ctrl,
	input  logic [data_width-1:0] a,
	input  logic [data_width-1:0] b,
	input  logic [7:0]            instr_imm,
	input  logic [data_width-1:0] rd_old,
	output logic [data_width-1:0] result,
	output flags_t                flags
);

	logic [data_width-1:0] imm_ext;
	logic [data_width-1:0] op_b;
	logic [data_width-1:0] res;
	logic ovf;

	// Immediate extension, 4 or 8 bits
	always_comb begin
		if (ctrl.imm_sel == IMM_4) begin
			imm_ext = ctrl.sign_ext_sel ? {{(data_width-4){instr_imm[3]}}, instr_imm[3:0]}
				: {{(data_width-4){1'b0}}, instr_imm[3:0]};
		end else begin
			imm_ext = ctrl.sign_ext_sel ? {{(data_width-8){instr_imm[7]}}, instr_imm}
				: {{(data_width-8){1'b0}}, instr_imm};
		end
	end

	assign op_b = ctrl.alu_src ? imm_ext : b;

	always_comb begin
		ovf = 1'b0;
		case (ctrl.alu_op)
			ALU_ADD, ALU_INC: begin
				res = a + op_b;
				ovf = (a[data_width-1] == op_b[data_width-1])
					&& (res[data_width-1] != a[data_width-1]); // Like signs, sign flips
			end
			ALU_SUB: begin
				res = a - op_b;
				ovf = (a[data_width-1] != op_b[data_width-1])
					&& (res[data_width-1] != a[data_width-1]);
			end
			ALU_NAND: res = ~(a & op_b);
			ALU_XOR:  res = a ^ op_b;
			ALU_SRA:  res = $signed(a) >>> op_b[3:0]; // Sign fill
			ALU_SRL:  res = a >> op_b[3:0];
			ALU_SLL:  res = a << op_b[3:0];
			default:  res = a + op_b;
		endcase

		// Stack and byte-load overrides
		if (ctrl.call) begin
			res = a - 1'b1; // Push slot below sp
			ovf = 1'b0;
		end else if (ctrl.rtrn) begin
			res = a; // Pop from sp itself
			ovf = 1'b0;
		end else if (ctrl.imm_sel == IMM_LHB) begin
			res = {instr_imm, rd_old[7:0]}; // Keep low byte
			ovf = 1'b0;
		end else if (ctrl.imm_sel == IMM_LLB) begin
			res = op_b;
			ovf = 1'b0;
		end
	end

	assign result = res;
	assign flags.z = (res == '0);
	assign flags.n = res[data_width-1];
	assign flags.v = ovf;

endmodule

// ==== hdl/reg_file.sv ====
// Register 0 reads as zero but may be written; reg_sp moves by one word on CALL and RET
`timescale 1ns/10ps

module reg_file import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  logic                      clk,
	input  logic                      arst_n,
	input  ctrl_t                     ctrl,
	input  logic [reg_addr_width-1:0] rs1,
	input  logic [reg_addr_width-1:0] rs2,
	input  logic [reg_addr_width-1:0] rd,
	input  logic [data_width-1:0]     wr_data,
	output logic [data_width-1:0]     rd_data_1,
	output logic [data_width-1:0]     rd_data_2,
	output logic [data_width-1:0]     rd_data_d,
	output logic [data_width-1:0]     sp
);

	localparam int num_regs = 2 ** reg_addr_width;

	logic [data_width-1:0] regs [num_regs];
	logic [reg_addr_width-1:0] sel_1; // Steered index for port one

	// Port one source follows the control word
	always_comb begin
		if (ctrl.data_reg) begin
			sel_1 = reg_ds;
		end else if (ctrl.call || ctrl.rtrn) begin
			sel_1 = reg_sp;
		end else begin
			sel_1 = rs1;
		end
	end

	// Zero register on every read port
	assign rd_data_1 = (sel_1 == '0) ? '0 : regs[sel_1];
	assign rd_data_2 = (rs2 == '0) ? '0 : regs[rs2];
	assign rd_data_d = (rd == '0) ? '0 : regs[rd]; // Store data and LHB low byte
	assign sp = regs[reg_sp];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else begin
			if (ctrl.reg_write) begin
				regs[rd] <= wr_data;
			end else if (ctrl.call) begin
				regs[reg_sp] <= regs[reg_sp] - 1'b1; // Push, stack grows down
			end else if (ctrl.rtrn) begin
				regs[reg_sp] <= regs[reg_sp] + 1'b1; // Pop
			end
		end
	end

endmodule

// ==== hdl/control_logic.sv ====
// Purely combinational decoder; any opcode outside the ISA decodes as a halt with no writes
`timescale 1ns/10ps

module control_logic import cpu_isa_pkg::*, cpu_ctrl_pkg::*; (
	input  opcode_t opcode,
	input  cond_t   cond,
	output ctrl_t   ctrl
);

	always_comb begin
		// Quiet word, each opcode turns on what it needs
		ctrl = '0;
		ctrl.cond = cond;
		ctrl.alu_op = alu_op_t'(opcode[2:0]); // ALU ops share the low opcode bits
		ctrl.imm_sel = IMM_4;

		case (opcode)
			ADD, SUB, NAND, XOR, SRA, SRL, SLL: begin
				ctrl.reg_write = 1'b1; // Register form
				ctrl.flag_write = 1'b1;
			end

			INC: begin
				ctrl.alu_src = 1'b1;
				ctrl.sign_ext_sel = 1'b1; // Signed imm4
				ctrl.reg_write = 1'b1;
				ctrl.flag_write = 1'b1;
			end

			LW: begin
				ctrl.data_reg = 1'b1; // Base from reg_ds
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_op = ALU_ADD;
				ctrl.alu_src = 1'b1;
				ctrl.imm_sel = IMM_8; // Zero extended offset
				ctrl.reg_write = 1'b1;
			end

			SW: begin
				ctrl.data_reg = 1'b1;
				ctrl.reg_to_mem = 1'b1;
				ctrl.alu_op = ALU_ADD; // Low bits would give SUB
				ctrl.alu_src = 1'b1;
				ctrl.imm_sel = IMM_8;
			end

			LHB: begin
				ctrl.alu_src = 1'b1;
				ctrl.imm_sel = IMM_LHB;
				ctrl.reg_write = 1'b1;
			end

			LLB: begin
				ctrl.alu_src = 1'b1;
				ctrl.sign_ext_sel = 1'b1;
				ctrl.imm_sel = IMM_LLB;
				ctrl.reg_write = 1'b1;
			end

			B: ctrl.branch = 1'b1; // Condition already passed through

			CALL: ctrl.call = 1'b1; // Push and jump

			RET: ctrl.rtrn = 1'b1; // Pop and jump

			ERR: ctrl.halt = 1'b1;

			default: ctrl.halt = 1'b1; // Unknown code stops the core
		endcase
	end

endmodule

// ==== hdl/cpu_ctrl_pkg.sv ====
// Control word layout shared by decoder and datapath; alu_op_t must track the low opcode bits
package cpu_ctrl_pkg;

	// Same order as opcodes 0 to 7
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_NAND, ALU_XOR, ALU_INC, ALU_SRA, ALU_SRL, ALU_SLL
	} alu_op_t;

	// Immediate source for operand two
	typedef enum logic [1:0] {
		IMM_4,   // Bits 3:0
		IMM_8,   // Bits 7:0
		IMM_LHB, // Merge into high byte
		IMM_LLB  // Sign extended low byte
	} imm_sel_t;

	typedef struct packed {
		logic z; // Result zero
		logic n; // Result negative
		logic v; // Signed overflow, add and sub only
	} flags_t;

	typedef struct packed {
		logic data_reg; // Read port one from reg_ds
		logic call;
		logic rtrn; // Read port one from reg_sp
		logic branch;
		cpu_isa_pkg::cond_t cond;
		logic mem_to_reg; // Writeback from dmem, also the read strobe
		logic reg_to_mem; // Store strobe
		alu_op_t alu_op;
		logic alu_src; // Immediate as operand two
		logic sign_ext_sel;
		logic reg_write;
		logic flag_write;
		imm_sel_t imm_sel;
		logic halt;
	} ctrl_t;

endpackage

// ==== hdl/cpu_isa_pkg.sv ====
// ISA encoding for the 16-bit core; field positions assume data_width 16 and pc_width 12
package cpu_isa_pkg;

	localparam int data_width = 16; // Word and register width
	localparam int pc_width = 12; // Instruction address width, 4K words
	localparam int reg_addr_width = 4; // Sixteen registers
	localparam int off_width = 9; // Branch offset, signed

	// Register roles
	localparam logic [reg_addr_width-1:0] reg_ds = 4'd14; // Data segment base for LW and SW
	localparam logic [reg_addr_width-1:0] reg_sp = 4'd15; // Stack pointer for CALL and RET

	// Opcodes, values follow declaration order
	typedef enum logic [3:0] {
		ADD,  // 0
		SUB,
		NAND,
		XOR,
		INC,  // rs1 plus signed imm4
		SRA,
		SRL,
		SLL,
		LW,   // 8
		SW,
		LHB,
		LLB,
		B,
		CALL,
		RET,
		ERR   // Halts the core
	} opcode_t;

	// Branch conditions on stored flags
	typedef enum logic [2:0] {
		EQ, LT, GT, OV, NE, GE, LE, TR
	} cond_t;

	// Common fields
	localparam int opc_hi = 15;
	localparam int opc_lo = 12;
	localparam int rd_hi = 11; // Destination register
	localparam int rd_lo = 8;
	localparam int rs1_hi = 7;
	localparam int rs1_lo = 4;
	localparam int rs2_hi = 3; // Also the 4-bit immediate
	localparam int rs2_lo = 0;

	// LW, SW, LHB, LLB
	localparam int imm8_hi = 7;
	localparam int imm8_lo = 0;

	// B
	localparam int cond_hi = 11;
	localparam int cond_lo = 9;
	localparam int off_hi = 8;
	localparam int off_lo = 0;

	// CALL absolute target
	localparam int tgt_hi = 11;
	localparam int tgt_lo = 0;

endpackage
